// ==== common/mips_pkg.sv ====
package mips_pkg;

    // ----------------------------------------
    // basic types
    // ----------------------------------------

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // primary opcodes kept from the MIPS subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // special functs
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    // debug tap register
    localparam reg_addr_t REG_LINK = 5'd28;

    // ----------------------------------------
    // pipeline payloads
    // ----------------------------------------

    // one register write, also used for forwarding
    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } rf_write_t;

    typedef struct packed {
        logic  valid;
        word_t pc4;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        alu_op_e   alu_op;
        logic      b_is_imm;
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm;
        reg_addr_t dest;
        logic      wr_en;
        logic      mem_rd;
        logic      mem_wr;
    } id_ex_t;

    typedef struct packed {
        word_t     alu_data;
        word_t     store_data;
        reg_addr_t dest;
        logic      wr_en;
        logic      mem_rd;
        logic      mem_wr;
    } ex_mem_t;

endpackage

// ==== fetch/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
    parameter mips_pkg::word_t RESET_PC = 32'h0040_0000
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             ena,
    input  logic             stall,
    input  logic             redirect,
    input  mips_pkg::word_t  target,
    input  mips_pkg::word_t  instr,
    output mips_pkg::word_t  pc,
    output mips_pkg::if_id_t if_id
);
    import mips_pkg::*;

    word_t pc4;

    assign pc4 = pc + 32'd4;

    // program counter, held on stall
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (ena && !stall) begin
            pc <= redirect ? target : pc4;
        end
    end

    // fetch/decode register
    // the word fetched behind a taken redirect is dropped here
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_id <= '0;
        end else if (ena && !stall) begin
            if_id.valid <= !redirect;
            if_id.pc4   <= pc4;
            if_id.instr <= instr;
        end
    end

endmodule

// ==== decode/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                clk,
    input  logic                arst_n,
    input  mips_pkg::rf_write_t wb,
    input  mips_pkg::reg_addr_t rs_addr,
    input  mips_pkg::reg_addr_t rt_addr,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    output mips_pkg::word_t     reg28
);
    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // $0 is hardwired, a write in flight is seen at once
    assign rs_data = (rs_addr == '0) ? '0 :
                     (wb.en && wb.addr == rs_addr) ? wb.data : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 :
                     (wb.en && wb.addr == rt_addr) ? wb.data : regs[rt_addr];

    assign reg28 = regs[REG_LINK];

endmodule

// ==== decode/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ena,
    input  mips_pkg::if_id_t    if_id,
    input  mips_pkg::rf_write_t ex_fwd,
    input  mips_pkg::rf_write_t mem_fwd,
    input  mips_pkg::rf_write_t wb,
    output logic                stall,
    output logic                redirect,
    output mips_pkg::word_t     target,
    output mips_pkg::id_ex_t    id_ex,
    output mips_pkg::word_t     reg28
);
    import mips_pkg::*;

    opcode_e   op;
    funct_e    fn;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    reg_addr_t rd_addr;
    reg_addr_t dest;
    word_t     imm;
    word_t     rf_rs;
    word_t     rf_rt;
    word_t     rs_val;
    word_t     rt_val;
    alu_op_e   alu_op;
    logic      b_is_imm;
    logic      wr_req;
    logic      mem_rd;
    logic      mem_wr;
    logic      use_rs;
    logic      use_rt;
    logic      is_beq;
    logic      is_bne;
    logic      is_j;
    logic      load_use;
    logic      taken;

    // youngest producer wins
    function automatic word_t pick_operand(input reg_addr_t addr, input word_t rf_val,
                                           input rf_write_t ex_w, input rf_write_t mem_w);
        if (ex_w.en && ex_w.addr == addr)
            return ex_w.data;
        if (mem_w.en && mem_w.addr == addr)
            return mem_w.data;
        return rf_val;
    endfunction

    reg_file reg_file_i (
        .clk(clk),
        .arst_n(arst_n),
        .wb(wb),
        .rs_addr(rs_addr),
        .rt_addr(rt_addr),
        .rs_data(rf_rs),
        .rt_data(rf_rt),
        .reg28(reg28)
    );

    assign op      = opcode_e'(if_id.instr[31:26]);
    assign fn      = funct_e'(if_id.instr[5:0]);
    assign rs_addr = if_id.instr[25:21];
    assign rt_addr = if_id.instr[20:16];
    assign rd_addr = if_id.instr[15:11];
    assign imm     = {{16{if_id.instr[15]}}, if_id.instr[15:0]};

    // ----------------------------------------
    // instruction decode
    // ----------------------------------------
    always_comb begin
        alu_op   = ALU_ADD;
        b_is_imm = 1'b0;
        dest     = rd_addr;
        wr_req   = 1'b0;
        mem_rd   = 1'b0;
        mem_wr   = 1'b0;
        use_rs   = 1'b0;
        use_rt   = 1'b0;
        is_beq   = 1'b0;
        is_bne   = 1'b0;
        is_j     = 1'b0;
        case (op)
            OP_SPECIAL: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
                wr_req = 1'b1;
                case (fn)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: begin
                        // unknown funct retires as a nop
                        use_rs = 1'b0;
                        use_rt = 1'b0;
                        wr_req = 1'b0;
                    end
                endcase
            end
            OP_ADDIU, OP_LW: begin
                use_rs   = 1'b1;
                b_is_imm = 1'b1;
                dest     = rt_addr;
                wr_req   = 1'b1;
                mem_rd   = (op == OP_LW);
            end
            OP_SW: begin
                use_rs   = 1'b1;
                use_rt   = 1'b1;
                b_is_imm = 1'b1;
                mem_wr   = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
                is_beq = (op == OP_BEQ);
                is_bne = (op == OP_BNE);
            end
            OP_J:    is_j = 1'b1;
            default: ;
        endcase
    end

    // ----------------------------------------
    // operands, hazard and branch
    // ----------------------------------------
    assign rs_val = pick_operand(rs_addr, rf_rs, ex_fwd, mem_fwd);
    assign rt_val = pick_operand(rt_addr, rf_rt, ex_fwd, mem_fwd);

    // load in execute whose result is needed now
    assign load_use = id_ex.valid && id_ex.mem_rd && id_ex.wr_en &&
                      ((use_rs && id_ex.dest == rs_addr) || (use_rt && id_ex.dest == rt_addr));
    assign stall    = if_id.valid && load_use;

    assign taken    = (is_beq && rs_val == rt_val) || (is_bne && rs_val != rt_val) || is_j;
    assign redirect = if_id.valid && !stall && taken;
    assign target   = is_j ? {if_id.pc4[31:28], if_id.instr[25:0], 2'b00}
                           : if_id.pc4 + {imm[29:0], 2'b00};

    // decode/execute register, bubble while stalled
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (ena) begin
            id_ex <= '{
                valid:    if_id.valid && !stall,
                alu_op:   alu_op,
                b_is_imm: b_is_imm,
                rs_data:  rs_val,
                rt_data:  rt_val,
                imm:      imm,
                dest:     dest,
                wr_en:    wr_req && (dest != '0),
                mem_rd:   mem_rd,
                mem_wr:   mem_wr
            };
        end
    end

endmodule

// ==== execute/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ena,
    input  mips_pkg::id_ex_t    id_ex,
    output mips_pkg::rf_write_t ex_fwd,
    output mips_pkg::ex_mem_t   ex_mem
);
    import mips_pkg::*;

    word_t b_operand;
    word_t alu_res;

    assign b_operand = id_ex.b_is_imm ? id_ex.imm : id_ex.rt_data;

    // add also serves as lw/sw address
    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: alu_res = id_ex.rs_data + b_operand;
            ALU_SUB: alu_res = id_ex.rs_data - b_operand;
            ALU_AND: alu_res = id_ex.rs_data & b_operand;
            ALU_OR:  alu_res = id_ex.rs_data | b_operand;
            ALU_SLT: alu_res = {31'd0, $signed(id_ex.rs_data) < $signed(b_operand)};
            default: alu_res = '0;
        endcase
    end

    // load data is not ready yet, so loads stay off this path
    assign ex_fwd = '{
        en:   id_ex.valid && id_ex.wr_en && !id_ex.mem_rd,
        addr: id_ex.dest,
        data: alu_res
    };

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else if (ena) begin
            ex_mem.alu_data   <= alu_res;
            ex_mem.store_data <= id_ex.rt_data;
            ex_mem.dest       <= id_ex.dest;
            ex_mem.wr_en      <= id_ex.valid && id_ex.wr_en;
            ex_mem.mem_rd     <= id_ex.valid && id_ex.mem_rd;
            ex_mem.mem_wr     <= id_ex.valid && id_ex.mem_wr;
        end
    end

endmodule

// ==== memory/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage #(
    parameter integer DMEM_WORDS = 256
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ena,
    input  mips_pkg::ex_mem_t   ex_mem,
    output mips_pkg::rf_write_t mem_fwd,
    output mips_pkg::rf_write_t wb
);
    import mips_pkg::*;

    localparam integer ADDR_W = $clog2(DMEM_WORDS);

    word_t             dmem [DMEM_WORDS];
    logic [ADDR_W-1:0] word_idx;
    word_t             load_data;
    rf_write_t         wb_q;

    // word addressed, low two bits ignored
    assign word_idx = ex_mem.alu_data[ADDR_W+1:2];

    always_ff @(posedge clk) begin
        if (ena && ex_mem.mem_wr) begin
            dmem[word_idx] <= ex_mem.store_data;
        end
    end

    assign load_data = dmem[word_idx];

    // writeback select
    assign mem_fwd = '{
        en:   ex_mem.wr_en,
        addr: ex_mem.dest,
        data: ex_mem.mem_rd ? load_data : ex_mem.alu_data
    };

    // memory/writeback register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_q <= '0;
        end else if (ena) begin
            wb_q <= mem_fwd;
        end
    end

    // no register write while frozen
    assign wb = '{en: wb_q.en && ena, addr: wb_q.addr, data: wb_q.data};

endmodule

// ==== verilog/cpu.sv ====
`timescale 1ns/1ps

module cpu #(
    parameter mips_pkg::word_t RESET_PC   = 32'h0040_0000,
    parameter integer          DMEM_WORDS = 256
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                ena,
    input  mips_pkg::word_t     instr,
    output mips_pkg::word_t     pc,
    output mips_pkg::rf_write_t wb,
    output mips_pkg::word_t     reg28
);
    import mips_pkg::*;

    // decode to fetch control
    logic      stall;
    logic      redirect;
    word_t     target;

    // stage registers
    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;

    // forwarding candidates into decode
    rf_write_t ex_fwd;
    rf_write_t mem_fwd;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) fetch_i (
        .clk(clk),
        .arst_n(arst_n),
        .ena(ena),
        .stall(stall),
        .redirect(redirect),
        .target(target),
        .instr(instr),
        .pc(pc),
        .if_id(if_id)
    );

    decode_stage decode_i (
        .clk(clk),
        .arst_n(arst_n),
        .ena(ena),
        .if_id(if_id),
        .ex_fwd(ex_fwd),
        .mem_fwd(mem_fwd),
        .wb(wb),
        .stall(stall),
        .redirect(redirect),
        .target(target),
        .id_ex(id_ex),
        .reg28(reg28)
    );

    execute_stage execute_i (
        .clk(clk),
        .arst_n(arst_n),
        .ena(ena),
        .id_ex(id_ex),
        .ex_fwd(ex_fwd),
        .ex_mem(ex_mem)
    );

    mem_stage #(
        .DMEM_WORDS(DMEM_WORDS)
    ) mem_i (
        .clk(clk),
        .arst_n(arst_n),
        .ena(ena),
        .ex_mem(ex_mem),
        .mem_fwd(mem_fwd),
        .wb(wb)
    );

endmodule

// ==== sim/cpu_asserts.sv ====
`timescale 1ns/1ps

module cpu_asserts (
    input logic                clk,
    input logic                arst_n,
    input logic                ena,
    input mips_pkg::word_t     pc,
    input mips_pkg::rf_write_t wb
);
    import mips_pkg::*;

    integer fail_count = 0;

    // register 0 is never written
    assert property (@(posedge clk) disable iff (!arst_n) wb.en |-> wb.addr != '0)
        else begin
            $error("register write to address 0");
            fail_count++;
        end

    // frozen pipeline keeps its pc
    assert property (@(posedge clk) disable iff (!arst_n) !ena |=> $stable(pc))
        else begin
            $error("pc moved in a cycle with ena low");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!arst_n) !ena |-> !wb.en)
        else begin
            $error("register write while ena is low");
            fail_count++;
        end

endmodule

bind cpu cpu_asserts asserts_i (
    .clk(clk),
    .arst_n(arst_n),
    .ena(ena),
    .pc(pc),
    .wb(wb)
);

// ==== sim/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;
    import mips_pkg::*;

    localparam word_t  RESET_PC   = 32'h0040_0000;
    localparam integer DMEM_WORDS = 256;
    localparam integer MAX_PROG   = 32;

    logic      clk = 1'b0;
    logic      arst_n;
    logic      ena;
    word_t     instr;
    word_t     pc;
    rf_write_t wb;
    word_t     reg28;

    word_t     prog [MAX_PROG];
    integer    prog_len = 0;
    rf_write_t exp_q [$];
    rf_write_t got_q [$];
    word_t     exp_reg28;
    integer    seed = 32'hfaaa;
    integer    errors = 0;
    integer    test_errors = 0;
    integer    tests_run = 0;
    integer    tests_failed = 0;
    integer    cycle = 0;
    integer    cycle_limit = 200;
    integer    rel_cycle = 0;
    integer    first_wr_cycle = 0;
    integer    low_left = 0;
    logic      rand_ena = 1'b0;

    cpu #(
        .RESET_PC(RESET_PC),
        .DMEM_WORDS(DMEM_WORDS)
    ) dut_i (
        .clk(clk),
        .arst_n(arst_n),
        .ena(ena),
        .instr(instr),
        .pc(pc),
        .wb(wb),
        .reg28(reg28)
    );

    always #50 clk = ~clk;

    // cycle count and run limit
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (arst_n)
            rel_cycle = rel_cycle + 1;
        if (cycle > cycle_limit) begin
            $display("timeout after %0d cycles, the run did not finish", cycle);
            $display("Some tests failed");
            $finish;
        end
    end

    // instruction memory and ena, just after the edge
    always @(posedge clk) begin
        #1;
        if (rand_ena && low_left == 0 && ($random(seed) & 7) == 0)
            low_left = 1 + ($random(seed) & 3);
        if (low_left > 0) begin
            ena = 1'b0;
            low_left = low_left - 1;
        end else begin
            ena = 1'b1;
        end
        instr = fetch_word(pc);
    end

    // writeback monitor
    always @(negedge clk) begin
        if (wb.en) begin
            if (!ena) begin
                $display("register write seen at %0t while ena is low", $time);
                test_errors++;
            end
            if (got_q.size() == 0)
                first_wr_cycle = rel_cycle;
            got_q.push_back(wb);
        end
    end

    // ----------------------------------------
    // program helpers
    // ----------------------------------------
    function automatic word_t fetch_word(input word_t addr);
        word_t idx;
        idx = (addr - RESET_PC) >> 2;
        if (addr >= RESET_PC && idx < prog_len)
            return prog[idx];
        return '0;
    endfunction

    function automatic word_t r_type(input funct_e fn, input reg_addr_t rd,
                                     input reg_addr_t rs, input reg_addr_t rt);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t i_type(input opcode_e op, input reg_addr_t rt,
                                     input reg_addr_t rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_type(input integer idx);
        word_t a;
        a = RESET_PC + 32'(idx) * 4;
        return {OP_J, a[27:2]};
    endfunction

    function automatic logic [15:0] rand_imm();
        return 16'($random(seed));
    endfunction

    task automatic emit(input word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program(input integer id);
        integer k;
        prog_len = 0;
        case (id)
            1: begin
                emit(i_type(OP_ADDIU, 5'd1, 5'd0, 16'h0011));
                emit(i_type(OP_ADDIU, 5'd2, 5'd1, 16'h0022));
            end
            2: begin
                emit(i_type(OP_ADDIU, 5'd1, 5'd0, rand_imm()));
                emit(i_type(OP_ADDIU, 5'd2, 5'd1, rand_imm()));
                emit(r_type(FN_ADDU, 5'd3, 5'd1, 5'd2));
                emit(r_type(FN_SUBU, 5'd4, 5'd3, 5'd1));
                emit(r_type(FN_AND, 5'd5, 5'd4, 5'd3));
                emit(r_type(FN_OR, 5'd6, 5'd5, 5'd2));
                emit(r_type(FN_SLT, 5'd7, 5'd6, 5'd4));
                emit(r_type(FN_SLT, 5'd8, 5'd4, 5'd6));
                emit(r_type(FN_SUBU, 5'd9, 5'd7, 5'd8));
                emit(r_type(FN_ADDU, 5'd10, 5'd9, 5'd9));
            end
            3: begin
                emit(i_type(OP_ADDIU, 5'd1, 5'd0, 16'h0040));
                emit(i_type(OP_ADDIU, 5'd2, 5'd0, rand_imm()));
                emit(i_type(OP_SW, 5'd2, 5'd1, 16'h0000));
                emit(i_type(OP_SW, 5'd1, 5'd1, 16'h0004));
                emit(i_type(OP_LW, 5'd3, 5'd1, 16'h0000));
                emit(r_type(FN_ADDU, 5'd4, 5'd3, 5'd3));
                emit(i_type(OP_LW, 5'd5, 5'd1, 16'h0004));
                emit(i_type(OP_ADDIU, 5'd6, 5'd0, 16'h0001));
                emit(r_type(FN_SUBU, 5'd7, 5'd5, 5'd6));
                emit(i_type(OP_LW, 5'd8, 5'd1, 16'h0000));
                emit(i_type(OP_SW, 5'd8, 5'd1, 16'h0008));
                emit(i_type(OP_LW, 5'd9, 5'd1, 16'h0008));
                emit(r_type(FN_OR, 5'd10, 5'd9, 5'd4));
            end
            4: begin
                emit(i_type(OP_ADDIU, 5'd1, 5'd0, 16'h0005));
                emit(i_type(OP_ADDIU, 5'd2, 5'd0, 16'h0005));
                emit(i_type(OP_BEQ, 5'd2, 5'd1, 16'h0001));
                emit(i_type(OP_ADDIU, 5'd3, 5'd0, 16'h0033));
                emit(i_type(OP_BNE, 5'd2, 5'd1, 16'h0001));
                emit(i_type(OP_ADDIU, 5'd4, 5'd0, 16'h0044));
                emit(i_type(OP_BNE, 5'd4, 5'd1, 16'h0001));
                emit(i_type(OP_ADDIU, 5'd5, 5'd0, 16'h0055));
                emit(j_type(10));
                emit(i_type(OP_ADDIU, 5'd6, 5'd0, 16'h0066));
                emit(i_type(OP_BEQ, 5'd1, 5'd0, 16'h0001));
                emit(i_type(OP_ADDIU, 5'd7, 5'd0, 16'h0077));
                emit(i_type(OP_BEQ, 5'd7, 5'd7, 16'h0001));
                emit(i_type(OP_ADDIU, 5'd8, 5'd0, 16'h0001));
                emit(i_type(OP_ADDIU, 5'd9, 5'd7, 16'h0001));
            end
            5: begin
                for (k = 1; k <= 8; k++)
                    emit(i_type(OP_ADDIU, k[4:0], 5'(k - 1), rand_imm()));
                emit(i_type(OP_SW, 5'd8, 5'd0, 16'h0020));
                emit(i_type(OP_LW, 5'd9, 5'd0, 16'h0020));
                emit(r_type(FN_ADDU, 5'd10, 5'd9, 5'd8));
                emit(r_type(FN_SUBU, 5'd11, 5'd10, 5'd1));
            end
            default: begin
                emit(i_type(OP_ADDIU, REG_LINK, 5'd0, rand_imm()));
                emit(i_type(OP_ADDIU, 5'd0, REG_LINK, rand_imm()));
                emit(r_type(FN_ADDU, 5'd0, REG_LINK, REG_LINK));
                emit(i_type(OP_ADDIU, REG_LINK, REG_LINK, rand_imm()));
                emit(r_type(FN_OR, REG_LINK, REG_LINK, 5'd0));
                emit(i_type(OP_ADDIU, 5'd0, 5'd0, 16'h0001));
            end
        endcase
    endtask

    // ----------------------------------------
    // architectural model
    // ----------------------------------------
    task automatic run_model();
        word_t     regs [32];
        word_t     mem [word_t];
        word_t     w;
        word_t     a;
        word_t     b;
        word_t     imm;
        word_t     res;
        word_t     tgt;
        reg_addr_t d;
        logic      wr;
        integer    idx;
        integer    steps;
        exp_q.delete();
        foreach (regs[i])
            regs[i] = '0;
        idx = 0;
        steps = 0;
        while (idx >= 0 && idx < prog_len && steps < 500) begin
            w = prog[idx];
            a = regs[w[25:21]];
            b = regs[w[20:16]];
            imm = {{16{w[15]}}, w[15:0]};
            d = w[20:16];
            wr = 1'b0;
            res = '0;
            steps++;
            idx++;
            case (w[31:26])
                OP_SPECIAL: begin
                    wr = 1'b1;
                    d = w[15:11];
                    case (w[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: begin
                    wr = 1'b1;
                    res = a + imm;
                end
                OP_LW: begin
                    wr = 1'b1;
                    res = mem.exists((a + imm) >> 2) ? mem[(a + imm) >> 2] : '0;
                end
                OP_SW:  mem[(a + imm) >> 2] = b;
                OP_BEQ: if (a == b) idx = idx + $signed(imm);
                OP_BNE: if (a != b) idx = idx + $signed(imm);
                OP_J: begin
                    tgt = RESET_PC + 32'(idx) * 4;
                    tgt = {tgt[31:28], w[25:0], 2'b00};
                    idx = (tgt - RESET_PC) >> 2;
                end
                default: ;
            endcase
            if (wr && d != '0) begin
                regs[d] = res;
                exp_q.push_back(rf_write_t'{en: 1'b1, addr: d, data: res});
            end
        end
        exp_reg28 = regs[REG_LINK];
    endtask

    // ----------------------------------------
    // checks and test flow
    // ----------------------------------------
    task automatic check_write(input rf_write_t got, input rf_write_t exp, input integer n);
        if (got !== exp) begin
            $display("[ERROR] %0t write %0d: got r%0d=%h, expected r%0d=%h",
                     $time, n, got.addr, got.data, exp.addr, exp.data);
            test_errors++;
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic start_test();
        #1;
        arst_n = 1'b0;
        rand_ena = 1'b0;
        test_errors = 0;
        got_q.delete();
        repeat (5) @(posedge clk);
        #1;
        rel_cycle = 0;
        arst_n = 1'b1;
    endtask

    task automatic run_and_compare();
        integer waited;
        integer n;
        run_model();
        waited = 0;
        while (got_q.size() < exp_q.size() && waited < 8 * prog_len + 40) begin
            @(posedge clk);
            waited++;
        end
        // let the pipeline drain with ena held high
        rand_ena = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        if (got_q.size() < exp_q.size()) begin
            $display("%0d of %0d expected register writes never appeared",
                     exp_q.size() - got_q.size(), exp_q.size());
            test_errors++;
        end
        n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
        for (int i = 0; i < n; i++)
            check_write(got_q[i], exp_q[i], i);
        if (got_q.size() > exp_q.size()) begin
            $display("%0d register writes appeared beyond the expected ones",
                     got_q.size() - exp_q.size());
            test_errors++;
        end
        check_word(reg28, exp_reg28, "reg28");
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
    endtask

    task automatic test_reset();
        build_program(1);
        start_test();
        check_word(pc, RESET_PC, "pc after reset");
        run_and_compare();
        if (got_q.size() > 0 && first_wr_cycle != 4) begin
            $display("[ERROR] %0t first write in cycle %0d, expected cycle 4",
                     $time, first_wr_cycle);
            test_errors++;
        end
        finish_test("reset");
    endtask

    task automatic test_alu_forwarding();
        build_program(2);
        start_test();
        run_and_compare();
        finish_test("alu_forwarding");
    endtask

    task automatic test_load_store();
        build_program(3);
        start_test();
        run_and_compare();
        finish_test("load_store");
    endtask

    task automatic test_branches();
        build_program(4);
        start_test();
        run_and_compare();
        finish_test("branches");
    endtask

    task automatic test_ena_freeze();
        build_program(5);
        start_test();
        rand_ena = 1'b1;
        run_and_compare();
        finish_test("ena_freeze");
    endtask

    task automatic test_reg0_reg28();
        build_program(6);
        start_test();
        run_and_compare();
        finish_test("reg0_reg28");
    endtask

    initial begin
        integer total;
        arst_n = 1'b0;
        ena = 1'b0;
        instr = '0;
        total = 0;
        for (int id = 1; id <= 6; id++) begin
            build_program(id);
            total += prog_len;
        end
        cycle_limit = 8 * total + 200;
        test_reset();
        test_alu_forwarding();
        test_load_store();
        test_branches();
        test_ena_freeze();
        test_reg0_reg28();
        errors += dut_i.asserts_i.fail_count;
        $display("%0d tests run, %0d failed, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, errors, dut_i.asserts_i.fail_count);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
common/mips_pkg.sv
fetch/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
memory/mem_stage.sv
verilog/cpu.sv
sim/cpu_asserts.sv
sim/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: mips_pipeline

sources:
  - files:
      - common/mips_pkg.sv
      - fetch/fetch_stage.sv
      - decode/reg_file.sv
      - decode/decode_stage.sv
      - execute/execute_stage.sv
      - memory/mem_stage.sv
      - verilog/cpu.sv
  - target: simulation
    files:
      - sim/cpu_asserts.sv
      - sim/cpu_tb.sv
